//--- sim.f
+incdir+design
design/fetch_pkg.sv
design/pc_gen.sv
design/icache_model.sv
design/pc_track_fifo.sv
design/if1_fifo_stage.sv
design/inst_queue.sv
design/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/fetch_tb.sv
`include "fetch_settings.svh"

module fetch_tb;

    localparam int RESET_CYCLES = 5;
    // pops per phase
    localparam int N_START  = 32;
    localparam int N_RANDOM = 24;
    localparam int N_ODD    = 20;
    localparam int N_FAULT  = 16;
    // four cycles per pop covers random deq, plus reset and flush slack
    localparam int CYCLE_LIMIT = RESET_CYCLES + 4 * (N_START + N_RANDOM + N_ODD + N_FAULT) + 200;
    // both redirect targets start on the odd word of a block
    localparam logic [31:0] ODD_PC  = `FETCH_RESET_PC + 32'h0000_0134;
    localparam logic [31:0] EDGE_PC = `ROM_LIMIT - 32'd20;

    logic        clk;
    logic        rstn;
    logic        flush;
    logic        deq;
    logic [31:0] redirect_pc;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic [8:0]  inst_excp;
    logic [31:0] inst_badv;
    // model state, owned by the compare process
    logic [31:0] exp_pc;
    logic        fault;
    logic [31:0] rng;
    int          errors = 0;
    int          pops = 0;
    int          cycles = 0;

    fetch_top fetch_i (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .deq         (deq),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_excp   (inst_excp),
        .inst_badv   (inst_badv)
    );

    bind fetch_top fetch_checker fetch_checker_i (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .deq           (deq),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .inst_excp     (inst_excp),
        .inst_badv     (inst_badv),
        .hold_state    (if1_i.hold_state),
        .icache_rready (icache_rready),
        .fifo_readygo  (fifo_readygo),
        .fifo_allowin  (fifo_allowin),
        .iq_count      (iq_i.count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // rom word at pc, nop past the limit
    function automatic logic [31:0] inst_at(input logic [31:0] pc);
        if (pc >= `ROM_LIMIT) begin
            return `INST_NOP;
        end
        return (pc >> 2) ^ `INST_SALT;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // deq high or random until n more pops are seen
    task automatic run_pops(input int n, input logic random_deq);
        int target;
        target = pops + n;
        while (pops < target) begin
            @(posedge clk);
            if (random_deq) begin
                rng = xorshift(rng);
                deq <= rng[7];
            end else begin
                deq <= 1'b1;
            end
        end
    endtask

    // one cycle flush pulse, no pop in the flush cycle
    task automatic redirect(input logic [31:0] pc);
        @(posedge clk);
        deq         <= 1'b0;
        flush       <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // compare, on values sampled before this edge
    always @(posedge clk) begin
        if (!rstn) begin
            check_value("inst_valid in reset", 32'(inst_valid), 32'd0);
            exp_pc = `FETCH_RESET_PC;
        end else if (flush) begin
            // everything older is gone
            exp_pc = redirect_pc;
        end else if (inst_valid && deq) begin
            fault = exp_pc >= `ROM_LIMIT;
            check_value("inst_pc", inst_pc, exp_pc);
            check_value("inst", inst, inst_at(exp_pc));
            check_value("inst_excp", 32'(inst_excp),
                        fault ? 32'({fetch_pkg::FLAG_FETCH, `EXC_ADEF}) : 32'd0);
            check_value("inst_badv", inst_badv, fault ? {exp_pc[31:3], 3'b000} : 32'd0);
            exp_pc = exp_pc + 32'd4;
            pops <= pops + 1;
        end
    end

    // stall guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d pops, fetch stream stalled",
                     cycles, pops);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        rstn        = 1'b0;
        flush       = 1'b0;
        deq         = 1'b0;
        redirect_pc = '0;
        rng         = 32'd69;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        // straight run from the reset pc
        run_pops(N_START, 1'b0);
        // same stream again under random back-pressure
        redirect(`FETCH_RESET_PC);
        run_pops(N_RANDOM, 1'b1);
        // odd word redirect
        redirect(ODD_PC);
        run_pops(N_ODD, 1'b1);
        // run across the rom limit into faults
        redirect(EDGE_PC);
        run_pops(N_FAULT, 1'b0);
        @(posedge clk);
        deq <= 1'b0;
        repeat (4) @(posedge clk);
        $display("%0d pops checked, %0d compare errors, %0d assertion failures",
                 pops, errors, fetch_i.fetch_checker_i.fail_count);
        if (errors == 0 && fetch_i.fetch_checker_i.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb/fetch_checker.sv
`include "fetch_settings.svh"

module fetch_checker (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         flush,
    input  logic                         deq,
    input  logic                         inst_valid,
    input  logic [`FETCH_XLEN-1:0]       inst,
    input  logic [`FETCH_XLEN-1:0]       inst_pc,
    input  logic [8:0]                   inst_excp,
    input  logic [`FETCH_XLEN-1:0]       inst_badv,
    input  fetch_pkg::hold_state_t       hold_state,
    input  logic                         icache_rready,
    input  logic                         fifo_readygo,
    input  logic                         fifo_allowin,
    input  logic [$clog2(`IQ_DEPTH):0]   iq_count
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // queue is empty while reset is held
    no_valid_in_reset: assert property (@(posedge clk) !rstn |-> !inst_valid)
        else begin
            fail_count++;
            $error("inst_valid high during reset");
        end

    // head entry must not move without a pop or a flush
    head_stable: assert property (@(posedge clk) disable iff (!rstn)
        (inst_valid && !deq && !flush) |=>
            (inst_valid && $stable({inst, inst_pc, inst_excp, inst_badv})))
        else begin
            fail_count++;
            $error("queue head changed while deq low");
        end

    // a response landing now would have to reopen pending
    hold_no_reentry: assert property (@(posedge clk) disable iff (!rstn)
        (hold_state == fetch_pkg::HOLD_WRITTEN) |-> !icache_rready)
        else begin
            fail_count++;
            $error("cache response arrived while hold entry was written");
        end

    // packet write never takes the queue past its depth
    write_has_room: assert property (@(posedge clk) disable iff (!rstn)
        (fifo_readygo && fifo_allowin) |=> (iq_count <= `IQ_DEPTH))
        else begin
            fail_count++;
            $error("queue write overfilled the queue");
        end

endmodule

//--- design/fetch_top.sv
`include "fetch_settings.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic [`FETCH_XLEN-1:0] redirect_pc,
    input  logic                   deq,
    output logic                   inst_valid,
    output logic [`FETCH_XLEN-1:0] inst,
    output logic [`FETCH_XLEN-1:0] inst_pc,
    output logic [8:0]             inst_excp,
    output logic [`FETCH_XLEN-1:0] inst_badv
);

    // if0 to cache
    logic [`FETCH_XLEN-1:0] fetch_pc;
    logic                   if1_allowin;
    // cache response
    logic                   icache_rready;
    logic [`FETCH_XLEN-1:0] pc_out;
    logic [`FETCH_XLEN-1:0] icache_pc_next;
    logic [`FETCH_XLEN-1:0] icache_inst0;
    logic [`FETCH_XLEN-1:0] icache_inst1;
    logic [`FETCH_XLEN-1:0] icache_badv;
    logic [6:0]             icache_exception;
    fetch_pkg::excp_flag_t  icache_excp_flag;
    // if1 packet into the queue
    logic                   fifo_readygo;
    logic [`FETCH_XLEN-1:0] if1_fifo_pc;
    logic [`FETCH_XLEN-1:0] if1_fifo_inst0;
    logic [`FETCH_XLEN-1:0] if1_fifo_inst1;
    logic [`FETCH_XLEN-1:0] if1_fifo_icache_badv;
    logic [6:0]             if1_fifo_icache_exception;
    fetch_pkg::excp_flag_t  if1_fifo_icache_excp_flag;
    // queue status back to if1
    logic                   fifo_allowin;
    logic                   space_ok;
    logic                   nearly_full;

    pc_gen pc_gen_i (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .if1_allowin (if1_allowin),
        .fetch_pc    (fetch_pc)
    );

    icache_model icache_i (
        .clk              (clk),
        .rstn             (rstn),
        .flush            (flush),
        .fetch_pc         (fetch_pc),
        .fetch_req        (if1_allowin),
        .icache_rready    (icache_rready),
        .pc_out           (pc_out),
        .icache_pc_next   (icache_pc_next),
        .icache_inst0     (icache_inst0),
        .icache_inst1     (icache_inst1),
        .icache_badv      (icache_badv),
        .icache_exception (icache_exception),
        .icache_excp_flag (icache_excp_flag)
    );

    // pc_next and pc_taken have no consumer without a predictor
    if1_fifo_stage if1_i (
        .clk                       (clk),
        .rstn                      (rstn),
        .flush                     (flush),
        .icache_rready             (icache_rready),
        .pc_out                    (pc_out),
        .icache_pc_next            (icache_pc_next),
        .icache_inst0              (icache_inst0),
        .icache_inst1              (icache_inst1),
        .icache_badv               (icache_badv),
        .icache_exception          (icache_exception),
        .icache_excp_flag          (icache_excp_flag),
        .fetch_pc                  (fetch_pc),
        .fifo_allowin              (fifo_allowin),
        .space_ok                  (space_ok),
        .nearly_full               (nearly_full),
        .if1_allowin               (if1_allowin),
        .fifo_readygo              (fifo_readygo),
        .if1_fifo_pc               (if1_fifo_pc),
        .if1_fifo_pc_next          (),
        .if1_fifo_pc_taken         (),
        .if1_fifo_inst0            (if1_fifo_inst0),
        .if1_fifo_inst1            (if1_fifo_inst1),
        .if1_fifo_icache_badv      (if1_fifo_icache_badv),
        .if1_fifo_icache_exception (if1_fifo_icache_exception),
        .if1_fifo_icache_excp_flag (if1_fifo_icache_excp_flag)
    );

    // queue qualifies readygo with its own allowin
    inst_queue iq_i (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .write_en     (fifo_readygo),
        .wr_pc        (if1_fifo_pc),
        .wr_inst0     (if1_fifo_inst0),
        .wr_inst1     (if1_fifo_inst1),
        .wr_badv      (if1_fifo_icache_badv),
        .wr_exception (if1_fifo_icache_exception),
        .wr_excp_flag (if1_fifo_icache_excp_flag),
        .deq          (deq),
        .fifo_allowin (fifo_allowin),
        .space_ok     (space_ok),
        .nearly_full  (nearly_full),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .inst_excp    (inst_excp),
        .inst_badv    (inst_badv)
    );

endmodule

//--- design/inst_queue.sv
`include "fetch_settings.svh"

module inst_queue (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   write_en,
    input  logic [`FETCH_XLEN-1:0] wr_pc,
    input  logic [`FETCH_XLEN-1:0] wr_inst0,
    input  logic [`FETCH_XLEN-1:0] wr_inst1,
    input  logic [`FETCH_XLEN-1:0] wr_badv,
    input  logic [6:0]             wr_exception,
    input  fetch_pkg::excp_flag_t  wr_excp_flag,
    input  logic                   deq,
    output logic                   fifo_allowin,
    output logic                   space_ok,
    output logic                   nearly_full,
    output logic                   inst_valid,
    output logic [`FETCH_XLEN-1:0] inst,
    output logic [`FETCH_XLEN-1:0] inst_pc,
    // {flag, code}
    output logic [8:0]             inst_excp,
    output logic [`FETCH_XLEN-1:0] inst_badv
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    logic [`FETCH_XLEN-1:0] q_pc   [`IQ_DEPTH];
    logic [`FETCH_XLEN-1:0] q_inst [`IQ_DEPTH];
    logic [`FETCH_XLEN-1:0] q_badv [`IQ_DEPTH];
    logic [8:0]             q_excp [`IQ_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       wr_ptr_nx;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic [PTR_W:0]         free_cnt;
    logic [PTR_W:0]         wr_num;
    logic                   wr_fire;
    logic                   single;
    logic                   pop;

    // packet accepted only with room for two entries
    assign wr_fire = write_en && fifo_allowin;
    // odd word start, slot 1 is the alignment nop
    assign single  = wr_pc[2];
    assign wr_num  = wr_fire ? (single ? (PTR_W + 1)'(1) : (PTR_W + 1)'(2)) : '0;
    assign pop     = inst_valid && deq;
    // power of two depth, pointers wrap by themselves
    assign wr_ptr_nx = wr_ptr + 1'b1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + wr_num[PTR_W-1:0];
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + wr_num - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && !flush) begin
            q_pc[wr_ptr]   <= wr_pc;
            q_inst[wr_ptr] <= wr_inst0;
            q_badv[wr_ptr] <= wr_badv;
            q_excp[wr_ptr] <= {wr_excp_flag, wr_exception};
            if (!single) begin
                // second word of the block
                q_pc[wr_ptr_nx]   <= wr_pc + `FETCH_XLEN'(4);
                q_inst[wr_ptr_nx] <= wr_inst1;
                q_badv[wr_ptr_nx] <= wr_badv;
                q_excp[wr_ptr_nx] <= {wr_excp_flag, wr_exception};
            end
        end
    end

    // free space levels for the if1 stage
    assign free_cnt     = (PTR_W + 1)'(`IQ_DEPTH) - count;
    assign fifo_allowin = free_cnt >= (PTR_W + 1)'(2);
    assign space_ok     = free_cnt >= (PTR_W + 1)'(4);
    assign nearly_full  = free_cnt <= (PTR_W + 1)'(1);

    // head entry toward decode
    assign inst_valid = count != '0;
    assign inst       = q_inst[rd_ptr];
    assign inst_pc    = q_pc[rd_ptr];
    assign inst_excp  = q_excp[rd_ptr];
    assign inst_badv  = q_badv[rd_ptr];

endmodule

//--- design/if1_fifo_stage.sv
`include "fetch_settings.svh"

module if1_fifo_stage (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   icache_rready,
    input  logic [`FETCH_XLEN-1:0] pc_out,
    input  logic [`FETCH_XLEN-1:0] icache_pc_next,
    input  logic [`FETCH_XLEN-1:0] icache_inst0,
    input  logic [`FETCH_XLEN-1:0] icache_inst1,
    input  logic [`FETCH_XLEN-1:0] icache_badv,
    input  logic [6:0]             icache_exception,
    input  fetch_pkg::excp_flag_t  icache_excp_flag,
    input  logic [`FETCH_XLEN-1:0] fetch_pc,
    input  logic                   fifo_allowin,
    input  logic                   space_ok,
    input  logic                   nearly_full,
    output logic                   if1_allowin,
    output logic                   fifo_readygo,
    output logic [`FETCH_XLEN-1:0] if1_fifo_pc,
    output logic [`FETCH_XLEN-1:0] if1_fifo_pc_next,
    output logic                   if1_fifo_pc_taken,
    output logic [`FETCH_XLEN-1:0] if1_fifo_inst0,
    output logic [`FETCH_XLEN-1:0] if1_fifo_inst1,
    output logic [`FETCH_XLEN-1:0] if1_fifo_icache_badv,
    output logic [6:0]             if1_fifo_icache_exception,
    output fetch_pkg::excp_flag_t  if1_fifo_icache_excp_flag
);

    fetch_pkg::hold_state_t hold_state;
    logic                   started;
    logic [1:0]             win;
    logic                   win_ok;
    logic                   pkt_valid;
    logic                   consume;
    logic                   pkt_free;
    logic                   take_direct;
    logic                   take_hold;
    logic                   capture;
    logic                   load_pkt;
    logic [`FETCH_XLEN-1:0] trk_head;
    logic                   trk_full;
    logic                   trk_empty;
    // hold register payload
    logic [`FETCH_XLEN-1:0] hold_pc;
    logic [`FETCH_XLEN-1:0] hold_pc_next;
    logic [`FETCH_XLEN-1:0] hold_inst0;
    logic [`FETCH_XLEN-1:0] hold_inst1;
    logic [`FETCH_XLEN-1:0] hold_badv;
    logic [6:0]             hold_exception;
    fetch_pkg::excp_flag_t  hold_excp_flag;
    // packet source, either the cache or the hold register
    logic [`FETCH_XLEN-1:0] src_pc;
    logic [`FETCH_XLEN-1:0] src_pc_next;
    logic [`FETCH_XLEN-1:0] src_inst0;
    logic [`FETCH_XLEN-1:0] src_inst1;
    logic [`FETCH_XLEN-1:0] src_badv;
    logic [6:0]             src_exception;
    fetch_pkg::excp_flag_t  src_excp_flag;

    // pcs of every issued block, popped when the queue takes it
    pc_track_fifo #(
        .DATA_WIDTH (`FETCH_XLEN),
        .DEPTH      (`TRACK_DEPTH)
    ) pc_track_i (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .write_en     (if1_allowin),
        .pop_en       (consume),
        .din          (fetch_pc),
        .dout         (trk_head),
        .full         (trk_full),
        .empty        (trk_empty),
        .nearly_full  (),
        .nearly_empty ()
    );

    // packet goes out only in order with the tracker head
    assign fifo_readygo = pkt_valid && !trk_empty && (trk_head == if1_fifo_pc);
    assign consume      = fifo_readygo && fifo_allowin;
    assign pkt_free     = !pkt_valid || consume;

    // response straight into the packet, else parked in hold
    assign take_direct = icache_rready && fifo_allowin && pkt_free
                         && (hold_state == fetch_pkg::HOLD_READY);
    assign capture     = icache_rready && !take_direct;
    assign take_hold   = (hold_state == fetch_pkg::HOLD_PENDING) && pkt_free && !nearly_full;
    assign load_pkt    = (take_direct || take_hold) && !flush;

    // at most two lookups outstanding in the cache pipe
    assign win_ok      = !(win[0] && win[1]);
    assign if1_allowin = started && space_ok && win_ok && !trk_full
                         && (hold_state == fetch_pkg::HOLD_READY);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // in-flight window, one bit per cycle of cache latency
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            win <= '0;
        end else if (flush) begin
            win <= '0;
        end else begin
            win <= {win[0], if1_allowin};
        end
    end

    // hold fsm
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_state <= fetch_pkg::HOLD_READY;
        end else if (flush) begin
            hold_state <= fetch_pkg::HOLD_READY;
        end else begin
            case (hold_state)
                fetch_pkg::HOLD_READY: begin
                    if (capture) begin
                        hold_state <= fetch_pkg::HOLD_PENDING;
                    end
                end
                fetch_pkg::HOLD_PENDING: begin
                    if (take_hold) begin
                        hold_state <= fetch_pkg::HOLD_WRITTEN;
                    end
                end
                fetch_pkg::HOLD_WRITTEN: begin
                    // keep fetch stopped until two packets fit again
                    if (space_ok) begin
                        hold_state <= fetch_pkg::HOLD_READY;
                    end
                end
                default: begin
                    hold_state <= fetch_pkg::HOLD_READY;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hold_pc        <= pc_out;
            hold_pc_next   <= icache_pc_next;
            hold_inst0     <= icache_inst0;
            hold_inst1     <= icache_inst1;
            hold_badv      <= icache_badv;
            hold_exception <= icache_exception;
            hold_excp_flag <= icache_excp_flag;
        end
    end

    always_comb begin
        if (hold_state == fetch_pkg::HOLD_PENDING) begin
            src_pc        = hold_pc;
            src_pc_next   = hold_pc_next;
            src_inst0     = hold_inst0;
            src_inst1     = hold_inst1;
            src_badv      = hold_badv;
            src_exception = hold_exception;
            src_excp_flag = hold_excp_flag;
        end else begin
            src_pc        = pc_out;
            src_pc_next   = icache_pc_next;
            src_inst0     = icache_inst0;
            src_inst1     = icache_inst1;
            src_badv      = icache_badv;
            src_exception = icache_exception;
            src_excp_flag = icache_excp_flag;
        end
    end

    // packet valid level
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pkt_valid <= 1'b0;
        end else if (flush) begin
            pkt_valid <= 1'b0;
        end else if (load_pkt) begin
            pkt_valid <= 1'b1;
        end else if (consume) begin
            pkt_valid <= 1'b0;
        end
    end

    // packet payload, odd word start moves inst1 into slot 0
    always_ff @(posedge clk) begin
        if (load_pkt) begin
            if1_fifo_pc               <= src_pc;
            if1_fifo_pc_next          <= src_pc_next;
            if1_fifo_pc_taken         <= 1'b0;
            if1_fifo_inst0            <= src_pc[2] ? src_inst1 : src_inst0;
            if1_fifo_inst1            <= src_pc[2] ? `INST_NOP : src_inst1;
            if1_fifo_icache_badv      <= src_badv;
            if1_fifo_icache_exception <= src_exception;
            if1_fifo_icache_excp_flag <= src_excp_flag;
        end
    end

endmodule

//--- design/pc_track_fifo.sv
module pc_track_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    input  logic                  write_en,
    input  logic                  pop_en,
    input  logic [DATA_WIDTH-1:0] din,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  full,
    output logic                  empty,
    output logic                  nearly_full,
    output logic                  nearly_empty
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    logic                  push;
    logic                  pop;

    // wrap at DEPTH, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // overflow and underflow requests are dropped
    assign push = write_en && !full;
    assign pop  = pop_en && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // head entry, oldest fetch still in flight
    assign dout         = mem[rd_ptr];
    assign full         = count == (PTR_W + 1)'(DEPTH);
    assign empty        = count == '0;
    assign nearly_full  = count >= (PTR_W + 1)'(DEPTH - 1);
    assign nearly_empty = count <= (PTR_W + 1)'(1);

endmodule

//--- design/icache_model.sv
`include "fetch_settings.svh"

module icache_model (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic [`FETCH_XLEN-1:0] fetch_pc,
    input  logic                   fetch_req,
    output logic                   icache_rready,
    output logic [`FETCH_XLEN-1:0] pc_out,
    output logic [`FETCH_XLEN-1:0] icache_pc_next,
    output logic [`FETCH_XLEN-1:0] icache_inst0,
    output logic [`FETCH_XLEN-1:0] icache_inst1,
    output logic [`FETCH_XLEN-1:0] icache_badv,
    output logic [6:0]             icache_exception,
    output fetch_pkg::excp_flag_t  icache_excp_flag
);

    // stage 1, lookup
    logic                   s1_valid;
    logic [`FETCH_XLEN-1:0] s1_pc;
    logic [`FETCH_XLEN-1:0] s1_base;
    logic                   s1_fault;

    // rom content is a pure function of the word address
    function automatic logic [`FETCH_XLEN-1:0] inst_word(input logic [`FETCH_XLEN-1:0] addr);
        return {2'b00, addr[`FETCH_XLEN-1:2]} ^ `INST_SALT;
    endfunction

    assign s1_base  = {s1_pc[`FETCH_XLEN-1:3], 3'b000};
    assign s1_fault = s1_pc >= `ROM_LIMIT;

    // valid bits, flush kills both stages at once
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid      <= 1'b0;
            icache_rready <= 1'b0;
        end else if (flush) begin
            s1_valid      <= 1'b0;
            icache_rready <= 1'b0;
        end else begin
            s1_valid      <= fetch_req;
            icache_rready <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req) begin
            s1_pc <= fetch_pc;
        end
    end

    // stage 2, data return
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            pc_out         <= s1_pc;
            icache_pc_next <= s1_base + `FETCH_XLEN'(8);
            if (s1_fault) begin
                // out of rom, nop words plus fault info
                icache_inst0     <= `INST_NOP;
                icache_inst1     <= `INST_NOP;
                icache_badv      <= s1_base;
                icache_exception <= `EXC_ADEF;
                icache_excp_flag <= fetch_pkg::FLAG_FETCH;
            end else begin
                icache_inst0     <= inst_word(s1_base);
                icache_inst1     <= inst_word(s1_base + `FETCH_XLEN'(4));
                icache_badv      <= '0;
                icache_exception <= '0;
                icache_excp_flag <= fetch_pkg::FLAG_NONE;
            end
        end
    end

endmodule

//--- design/pc_gen.sv
`include "fetch_settings.svh"

module pc_gen (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic [`FETCH_XLEN-1:0] redirect_pc,
    input  logic                   if1_allowin,
    output logic [`FETCH_XLEN-1:0] fetch_pc
);

    // next sequential block, aligned to 8 bytes
    logic [`FETCH_XLEN-1:0] next_block;

    assign next_block = {fetch_pc[`FETCH_XLEN-1:3], 3'b000} + `FETCH_XLEN'(8);

    // if0 pc register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_pc <= `FETCH_RESET_PC;
        end else if (flush) begin
            // redirect wins over a request in the same cycle
            fetch_pc <= redirect_pc;
        end else if (if1_allowin) begin
            // request taken, step to the following block
            fetch_pc <= next_block;
        end
    end

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

    // if1 hold register
    // HOLD_PENDING   response captured, not yet in the packet register
    // HOLD_WRITTEN   moved on, fetch still waits for queue space
    typedef enum logic [1:0] {
        HOLD_READY   = 2'd0,
        HOLD_PENDING = 2'd1,
        HOLD_WRITTEN = 2'd2
    } hold_state_t;

    // exception flag riding with every fetch block
    // only the fetch address fault exists in this front end
    typedef enum logic [1:0] {
        FLAG_NONE  = 2'b00,
        FLAG_FETCH = 2'b01
    } excp_flag_t;

endpackage

//--- design/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// address and instruction width
`define FETCH_XLEN      32
// andi r0,r0,0 fills the unused second slot
`define INST_NOP        32'h0340_0000
// first fetch block after reset
`define FETCH_RESET_PC  32'h1c00_0000
// first faulting address, rom ends just below
`define ROM_LIMIT       32'h1c01_0000
// xor pattern applied to the word address to form the instruction
`define INST_SALT       32'h2c5a_9e31
// fetch address fault code
`define EXC_ADEF        7'h08
// pc tracker depth, in-flight fetch blocks
`define TRACK_DEPTH     4
// instruction queue depth, single instructions
`define IQ_DEPTH        8

`endif
